// ==== rtl/pix_pkg.sv ====
// pixels are 8-bit RGB with red in the top byte; the window is fixed at 4x4 for the bicubic kernel
package pix_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    localparam int win_rows_c = 4;
    localparam int win_cols_c = 4;

    // element 0 is the leftmost pixel of the row
    typedef pixel_t [win_cols_c-1:0] window_row_t;

    // element 0 is the oldest image row of the band
    typedef window_row_t [win_rows_c-1:0] window_t;

    // one pixel per band row taken at the same column, element 0 from the oldest row
    typedef pixel_t [win_rows_c-1:0] column_t;

endpackage

// ==== rtl/lbuf_ctrl_pkg.sv ====
// bank numbers are only legal from 0 to 4; bank_add expects both operands inside that range
package lbuf_ctrl_pkg;

    localparam int num_banks_c = 5;

    typedef logic [2:0] bank_idx_t;

    typedef enum logic [1:0] {
        seq_fill    = 2'd0,
        seq_stream  = 2'd1,
        seq_restart = 2'd2
    } seq_state_e;

    // one column read; first_col marks column 0 of a band
    typedef struct packed {
        logic valid;
        logic first_col;
    } rd_issue_t;

    // bank rotation is modulo the number of row memories
    function automatic bank_idx_t bank_add(bank_idx_t base, bank_idx_t offs);
        logic [3:0] sum;
        sum = {1'b0, base} + {1'b0, offs};
        if (sum >= 4'(num_banks_c)) begin
            sum = sum - 4'(num_banks_c);
        end
        return bank_idx_t'(sum);
    endfunction

endpackage

// ==== rtl/row_sram.sv ====
// single-port row memory; a write cycle returns no read data and rdata keeps its last value
`timescale 1ns/10ps

module row_sram #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  pix_pkg::pixel_t          wdata,
    output pix_pkg::pixel_t          rdata
);

    pix_pkg::pixel_t mem [DEPTH];

    // read data shows up on the cycle after the access
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== rtl/row_bank_array.sv ====
// the write bank must never be one of the four banks being read in the same cycle
`timescale 1ns/10ps

module row_bank_array #(
    parameter int IMG_WIDTH = 8
) (
    input  logic                         clk,
    input  pix_pkg::pixel_t              pix,
    input  logic                         wr_en,
    input  lbuf_ctrl_pkg::bank_idx_t     wr_bank,
    input  logic [$clog2(IMG_WIDTH)-1:0] wr_addr,
    input  logic                         rd_en,
    input  logic [$clog2(IMG_WIDTH)-1:0] rd_addr,
    input  lbuf_ctrl_pkg::bank_idx_t     base_bank,
    output pix_pkg::column_t             col_data
);

    localparam int addr_w = $clog2(IMG_WIDTH);

    pix_pkg::pixel_t          bank_rdata [lbuf_ctrl_pkg::num_banks_c];
    lbuf_ctrl_pkg::bank_idx_t base_q;

    for (genvar b = 0; b < lbuf_ctrl_pkg::num_banks_c; b++) begin : g_bank
        logic              is_wr;
        logic              bank_en;
        logic [addr_w-1:0] bank_addr;

        // the write bank takes the write address, all others follow the read column
        assign is_wr     = (wr_bank == lbuf_ctrl_pkg::bank_idx_t'(b));
        assign bank_en   = is_wr ? wr_en : rd_en;
        assign bank_addr = is_wr ? wr_addr : rd_addr;

        row_sram #(
            .DEPTH (IMG_WIDTH)
        ) u_sram (
            .clk   (clk),
            .en    (bank_en),
            .we    (is_wr),
            .addr  (bank_addr),
            .wdata (pix),
            .rdata (bank_rdata[b])
        );
    end

    // base_bank may advance right after the last read of a band,
    // so keep the value that belongs to the data in flight
    always_ff @(posedge clk) begin
        if (rd_en) begin
            base_q <= base_bank;
        end
    end

    always_comb begin
        for (int r = 0; r < pix_pkg::win_rows_c; r++) begin
            col_data[r] = bank_rdata[lbuf_ctrl_pkg::bank_add(base_q,
                                                             lbuf_ctrl_pkg::bank_idx_t'(r))];
        end
    end

endmodule

// ==== rtl/buffer_sequencer.sv ====
// expects whole frames in row-major order, IMG_WIDTH >= 4 and IMG_HEIGHT >= 5, no edge padding
`timescale 1ns/10ps

module buffer_sequencer #(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 7
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pix_valid,
    output logic                         pix_ready,
    output logic                         wr_en,
    output lbuf_ctrl_pkg::bank_idx_t     wr_bank,
    output logic [$clog2(IMG_WIDTH)-1:0] wr_addr,
    output logic                         rd_en,
    output logic [$clog2(IMG_WIDTH)-1:0] rd_addr,
    output lbuf_ctrl_pkg::bank_idx_t     base_bank,
    output lbuf_ctrl_pkg::rd_issue_t     rd_issue,
    input  logic                         col_ready
);

    localparam int addr_w = $clog2(IMG_WIDTH);
    localparam int band_w = $clog2(IMG_HEIGHT);

    localparam logic [addr_w-1:0] last_col_c  = addr_w'(IMG_WIDTH - 1);
    localparam logic [band_w-1:0] last_band_c = band_w'(IMG_HEIGHT - pix_pkg::win_rows_c);

    lbuf_ctrl_pkg::seq_state_e state;
    lbuf_ctrl_pkg::bank_idx_t  spare_bank;

    logic [addr_w-1:0] wr_col;
    logic [addr_w-1:0] rd_col;
    logic [1:0]        rows_written;
    logic [band_w-1:0] band;
    logic              rd_done;
    logic              wr_done;
    logic              next_row;
    logic              pix_acc;
    logic              wr_last;
    logic              rd_last;
    logic              band_end;

    assign spare_bank = lbuf_ctrl_pkg::bank_add(base_bank, 3'd4);

    // true while a row below the current band is still to arrive
    assign next_row = (int'(band) + pix_pkg::win_rows_c) < IMG_HEIGHT;

    assign pix_ready = (state == lbuf_ctrl_pkg::seq_fill) ||
                       ((state == lbuf_ctrl_pkg::seq_stream) && next_row && !wr_done);

    assign pix_acc = pix_valid && pix_ready;
    assign wr_last = (wr_col == last_col_c);
    assign wr_en   = pix_acc;
    assign wr_addr = wr_col;

    // base_bank is zero during fill, so row i lands in bank i
    assign wr_bank = (state == lbuf_ctrl_pkg::seq_fill) ?
                     lbuf_ctrl_pkg::bank_add(base_bank, lbuf_ctrl_pkg::bank_idx_t'(rows_written)) :
                     spare_bank;

    assign rd_en   = (state == lbuf_ctrl_pkg::seq_stream) && !rd_done && col_ready;
    assign rd_addr = rd_col;
    assign rd_last = (rd_col == last_col_c);

    assign rd_issue.valid     = rd_en;
    assign rd_issue.first_col = rd_en && (rd_col == '0);

    assign band_end = (state == lbuf_ctrl_pkg::seq_stream) && rd_done && (wr_done || !next_row);

    // column counters for both sides of the bank array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_col  <= '0;
            rd_col  <= '0;
            rd_done <= 1'b0;
        end else begin
            if (pix_acc) begin
                wr_col <= wr_last ? '0 : wr_col + 1'b1;
            end
            if (rd_en) begin
                rd_col <= rd_last ? '0 : rd_col + 1'b1;
            end
            if (rd_en && rd_last) begin
                rd_done <= 1'b1;
            end else if (band_end) begin
                rd_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lbuf_ctrl_pkg::seq_fill;
            rows_written <= '0;
            band         <= '0;
            wr_done      <= 1'b0;
            base_bank    <= '0;
        end else begin
            case (state)
                lbuf_ctrl_pkg::seq_fill: begin
                    if (pix_acc && wr_last) begin
                        rows_written <= rows_written + 2'd1;
                        if (rows_written == 2'd3) begin
                            state <= lbuf_ctrl_pkg::seq_stream;
                        end
                    end
                end
                lbuf_ctrl_pkg::seq_stream: begin
                    if (band_end) begin
                        wr_done <= 1'b0;
                        if (band == last_band_c) begin
                            state <= lbuf_ctrl_pkg::seq_restart;
                        end else begin
                            band      <= band + 1'b1;
                            base_bank <= lbuf_ctrl_pkg::bank_add(base_bank, 3'd1);
                        end
                    end else if (pix_acc && wr_last) begin
                        wr_done <= 1'b1;
                    end
                end
                default: begin
                    // the next frame starts again from bank 0
                    state        <= lbuf_ctrl_pkg::seq_fill;
                    rows_written <= '0;
                    band         <= '0;
                    base_bank    <= '0;
                end
            endcase
        end
    end

endmodule

// ==== rtl/window_shifter.sv ====
// column data must arrive one cycle after its rd_issue; reads beyond col_ready overrun the queue
`timescale 1ns/10ps

module window_shifter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lbuf_ctrl_pkg::rd_issue_t rd_issue,
    input  pix_pkg::column_t         col_data,
    output logic                     col_ready,
    output pix_pkg::window_t         win,
    output logic                     win_valid,
    input  logic                     win_ready
);

    lbuf_ctrl_pkg::rd_issue_t issue_q;
    pix_pkg::column_t         q_data [2];
    pix_pkg::column_t         head_data;
    logic [1:0]               q_first;
    logic [1:0]               q_cnt;
    logic [2:0]               band_cols;
    logic [2:0]               next_cols;
    logic                     head_first;
    logic                     have_col;
    logic                     shift_ok;
    logic                     do_shift;
    logic                     push;
    logic                     pop;
    logic                     wr_slot;

    // the column still in flight from the bank array counts as pending
    assign col_ready = (q_cnt + {1'b0, issue_q.valid}) < 2'd2;

    assign have_col   = (q_cnt != 2'd0) || issue_q.valid;
    assign head_data  = (q_cnt != 2'd0) ? q_data[0] : col_data;
    assign head_first = (q_cnt != 2'd0) ? q_first[0] : issue_q.first_col;

    // a pending window is only overwritten when it is taken in the same cycle
    assign shift_ok = (band_cols < 3'd3) || !win_valid || win_ready;
    assign do_shift = have_col && shift_ok;

    assign pop     = do_shift && (q_cnt != 2'd0);
    assign push    = issue_q.valid && !(do_shift && (q_cnt == 2'd0));
    assign wr_slot = pop ? (q_cnt == 2'd2) : (q_cnt == 2'd1);

    assign next_cols = head_first ? 3'd1 : ((band_cols == 3'd4) ? 3'd4 : band_cols + 3'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q   <= '0;
            q_cnt     <= '0;
            band_cols <= '0;
            win_valid <= 1'b0;
        end else begin
            issue_q <= rd_issue;
            if (push && !pop) begin
                q_cnt <= q_cnt + 2'd1;
            end else if (pop && !push) begin
                q_cnt <= q_cnt - 2'd1;
            end
            if (do_shift) begin
                band_cols <= next_cols;
                win_valid <= (next_cols == 3'd4);
            end else if (win_ready) begin
                win_valid <= 1'b0;
            end
        end
    end

    // a push into the slot just vacated by a pop overrides the move
    always_ff @(posedge clk) begin
        if (pop) begin
            q_data[0]  <= q_data[1];
            q_first[0] <= q_first[1];
        end
        if (push) begin
            q_data[wr_slot]  <= col_data;
            q_first[wr_slot] <= issue_q.first_col;
        end
    end

    // newest column enters on the right
    always_ff @(posedge clk) begin
        if (do_shift) begin
            for (int r = 0; r < pix_pkg::win_rows_c; r++) begin
                win[r] <= {head_data[r], win[r][pix_pkg::win_cols_c-1:1]};
            end
        end
    end

endmodule

// ==== rtl/line_buffer_top.sv ====
// image size is fixed per build; every 4x4 window of each frame is emitted in raster order
`timescale 1ns/10ps

module line_buffer_top #(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 7
) (
    input  logic             clk,
    input  logic             rst_n,
    input  pix_pkg::pixel_t  pix,
    input  logic             pix_valid,
    output logic             pix_ready,
    output pix_pkg::window_t win,
    output logic             win_valid,
    input  logic             win_ready
);

    localparam int addr_w = $clog2(IMG_WIDTH);

    logic                     wr_en;
    lbuf_ctrl_pkg::bank_idx_t wr_bank;
    logic [addr_w-1:0]        wr_addr;
    logic                     rd_en;
    logic [addr_w-1:0]        rd_addr;
    lbuf_ctrl_pkg::bank_idx_t base_bank;
    lbuf_ctrl_pkg::rd_issue_t rd_issue;
    pix_pkg::column_t         col_data;
    logic                     col_ready;

    buffer_sequencer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .base_bank (base_bank),
        .rd_issue  (rd_issue),
        .col_ready (col_ready)
    );

    row_bank_array #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_banks (
        .clk       (clk),
        .pix       (pix),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .base_bank (base_bank),
        .col_data  (col_data)
    );

    window_shifter u_shift (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_issue  (rd_issue),
        .col_data  (col_data),
        .col_ready (col_ready),
        .win       (win),
        .win_valid (win_valid),
        .win_ready (win_ready)
    );

endmodule

// ==== dv/line_buffer_checker.sv ====
// stream rules of the line buffer top; the handshake checks are off while rst_n is low
`timescale 1ns/10ps

module line_buffer_checker (
    input logic             clk,
    input logic             rst_n,
    input pix_pkg::pixel_t  pix,
    input logic             pix_valid,
    input logic             pix_ready,
    input pix_pkg::window_t win,
    input logic             win_valid,
    input logic             win_ready
);

    int assert_fails = 0;

    // a stalled window must neither change nor disappear
    a_win_stable: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> win_valid && $stable(win))
        else begin
            assert_fails++;
            $error("window changed or dropped while stalled");
        end

    // once offered, input ready stays up until a pixel is taken
    a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_ready && !pix_valid |=> pix_ready)
        else begin
            assert_fails++;
            $error("pix_ready fell without a transfer");
        end

    // the source keeps a refused pixel in place
    a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
        else begin
            assert_fails++;
            $error("pixel changed or dropped while not accepted");
        end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !win_valid)
        else begin
            assert_fails++;
            $error("win_valid high during reset");
        end

endmodule

// ==== dv/tb_line_buffer.sv ====
// runs one 8x7 frame per table case back to back; pixels, gaps and stalls all come from one LFSR
`timescale 1ns/10ps

module tb_line_buffer;

    localparam int img_w      = 8;
    localparam int img_h      = 7;
    localparam int num_cases  = 5;
    localparam int frame_px   = img_w * img_h;
    localparam int frame_win  = (img_h - 3) * (img_w - 3);
    localparam int max_cycles = 20000;

    // gap_prob and stall_prob are out of 256
    typedef struct {
        string name;
        int    gap_prob;
        int    stall_prob;
    } case_t;

    logic             clk;
    logic             rst_n;
    pix_pkg::pixel_t  pix;
    logic             pix_valid;
    logic             pix_ready;
    pix_pkg::window_t win;
    logic             win_valid;
    logic             win_ready;

    case_t           cases [num_cases];
    pix_pkg::pixel_t img [num_cases][img_h][img_w];
    int              win_total;
    logic [31:0]     lfsr;
    int              p_case;
    int              p_idx;
    int              c_case;
    int              c_idx;
    int              win_errs;
    int              count_errs;
    int              flag_errs;
    int              limit_errs;
    int              timeouts;

    line_buffer_top #(
        .IMG_WIDTH  (img_w),
        .IMG_HEIGHT (img_h)
    ) dut0 (.*);

    bind line_buffer_top line_buffer_checker chk0 (
        .clk (clk), .rst_n (rst_n), .pix (pix), .pix_valid (pix_valid),
        .pix_ready (pix_ready), .win (win), .win_valid (win_valid), .win_ready (win_ready)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // window idx of a frame: band idx / (W-3), right column 3 + idx % (W-3)
    function automatic pix_pkg::window_t expected_window(int cs, int idx);
        pix_pkg::window_t w;
        int g;
        int c;
        g = idx / (img_w - 3);
        c = 3 + idx % (img_w - 3);
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                w[r][k] = img[cs][g + r][c - 3 + k];
            end
        end
        return w;
    endfunction

    // band g+1 cannot finish while band g still holds a window, so row g+5 is the last one in;
    // during the last band the next frame may fill and also take its first spare row
    function automatic int row_limit(int cs, int g);
        if (g < img_h - 4) begin
            return cs * img_h + g + 6;
        end
        return (cs + 1) * img_h + 5;
    endfunction

    task automatic check_window(string name, int idx, pix_pkg::window_t exp,
                                pix_pkg::window_t act);
        if (act !== exp) begin
            win_errs++;
            $display("ERROR %s window %0d: expected %h actual %h", name, idx, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            count_errs++;
            $display("ERROR %s window count: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("ERROR %s flag: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_limit(string name, int limit, int act);
        if (act > limit) begin
            limit_errs++;
            $display("ERROR %s accepted pixels: expected at most %0d actual %0d",
                     name, limit, act);
        end
    endtask

    initial begin
        logic [31:0] bits;
        logic        in_fire;
        logic        out_fire;
        int          cycles;
        int          total;
        clk       = 1'b0;
        rst_n     = 1'b1;
        pix       = '0;
        pix_valid = 1'b0;
        win_ready = 1'b0;
        lfsr      = 32'h5e8e2005;
        cases[0]  = '{"steady", 0, 0};
        cases[1]  = '{"input_gaps", 100, 0};
        cases[2]  = '{"output_stalls", 0, 140};
        cases[3]  = '{"gaps_and_stalls", 80, 110};
        cases[4]  = '{"heavy_stalls", 40, 220};
        for (int cs = 0; cs < num_cases; cs++) begin
            for (int r = 0; r < img_h; r++) begin
                for (int c = 0; c < img_w; c++) begin
                    bits = take_bits(24);
                    img[cs][r][c] = bits[23:0];
                end
            end
        end
        p_case     = 0;
        p_idx      = 0;
        c_case     = 0;
        c_idx      = 0;
        win_total  = 0;
        win_errs   = 0;
        count_errs = 0;
        flag_errs  = 0;
        limit_errs = 0;
        timeouts   = 0;

        @(posedge clk);
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset", 1'b0, win_valid);
        check_flag("reset", 1'b1, pix_ready);

        // sample at the falling edge, update and drive at the rising edge
        cycles = 0;
        while (c_case < num_cases && cycles < max_cycles) begin
            @(negedge clk);
            in_fire  = pix_valid && pix_ready;
            out_fire = win_valid && win_ready;
            if (out_fire) begin
                check_window(cases[c_case].name, c_idx, expected_window(c_case, c_idx), win);
            end
            check_limit(cases[c_case].name, row_limit(c_case, c_idx / (img_w - 3)) * img_w,
                        p_case * frame_px + p_idx);
            @(posedge clk);
            if (in_fire) begin
                p_idx++;
                if (p_idx == frame_px) begin
                    p_case++;
                    p_idx = 0;
                end
            end
            if (out_fire) begin
                win_total++;
                c_idx++;
                if (c_idx == frame_win) begin
                    c_case++;
                    c_idx = 0;
                end
            end
            if (p_case >= num_cases) begin
                pix_valid <= 1'b0;
            end else if (!pix_valid || in_fire) begin
                if (take_bits(8) < cases[p_case].gap_prob) begin
                    pix_valid <= 1'b0;
                end else begin
                    pix_valid <= 1'b1;
                    pix       <= img[p_case][p_idx / img_w][p_idx % img_w];
                end
            end
            if (c_case < num_cases) begin
                win_ready <= (take_bits(8) >= cases[c_case].stall_prob);
            end else begin
                win_ready <= 1'b1;
            end
            cycles++;
        end
        if (c_case < num_cases) begin
            timeouts++;
            $display("timeout: windows stopped in frame %0d at window %0d after %0d cycles",
                     c_case, c_idx, cycles);
        end

        // nothing may follow the last window of the last frame
        repeat (40) begin
            @(negedge clk);
            if (win_valid && win_ready) begin
                win_total++;
            end
        end
        check_count("all_frames", num_cases * frame_win, win_total);
        check_flag("idle", 1'b1, pix_ready);

        total = win_errs + count_errs + flag_errs + limit_errs + timeouts +
                dut0.chk0.assert_fails;
        $display("errors: window %0d, count %0d, flag %0d, limit %0d, timeout %0d, assert %0d",
                 win_errs, count_errs, flag_errs, limit_errs, timeouts, dut0.chk0.assert_fails);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/pix_pkg.sv
rtl/lbuf_ctrl_pkg.sv
rtl/row_sram.sv
rtl/row_bank_array.sv
rtl/buffer_sequencer.sv
rtl/window_shifter.sv
rtl/line_buffer_top.sv
dv/line_buffer_checker.sv
dv/tb_line_buffer.sv

// ==== Bender.yml ====
package:
  name: line_buffer

sources:
  - rtl/pix_pkg.sv
  - rtl/lbuf_ctrl_pkg.sv
  - rtl/row_sram.sv
  - rtl/row_bank_array.sv
  - rtl/buffer_sequencer.sv
  - rtl/window_shifter.sv
  - rtl/line_buffer_top.sv
  - target: test
    files:
      - dv/line_buffer_checker.sv
      - dv/tb_line_buffer.sv
